//--- files.f
logic/bch_pkg.sv
logic/bch_syndrome.sv
logic/bch_sigma.sv
logic/bch_chien.sv
logic/bch_correct.sv
logic/bch_decoder.sv
verif/bch_decoder_tb.sv

//--- logic/bch_chien.sv
`timescale 1ns/1ns

module bch_chien
	import bch_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    sig_valid,
	output logic    sig_ready,
	input  sigma_t  sig,
	output logic    root_valid,
	output logic    root_first,
	output logic    root_last,
	output logic    root_hit,
	output sigma_t  root_info,
	input  logic    sink_free
);

	chien_state_t state;
	gf_t          step_cnt;     // walks alpha^1 .. alpha^15 through the search
	sigma_t       info_q;
	logic         accept;
	gf_t          sig_coef [1:corr_t];
	gf_t          term [1:corr_t];
	gf_t          eval;

	assign sig_ready = (state == ch_idle);
	assign accept = sig_valid && sig_ready;
	assign sig_coef[1] = sig.sig1;
	assign sig_coef[2] = sig.sig2;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ch_idle;
			step_cnt <= gf_alpha;
		end else begin
			case (state)
				ch_idle: begin
					if (accept) state <= sink_free ? ch_search : ch_hold;
				end
				ch_hold: begin
					if (sink_free) state <= ch_search;
				end
				ch_search: begin
					if (step_cnt == gf_one) state <= ch_idle;
				end
				default: state <= ch_idle;
			endcase
			if (accept) step_cnt <= gf_alpha;
			else if (state == ch_search)
				step_cnt <= {step_cnt[2:0], 1'b0} ^ (step_cnt[3] ? field_poly[3:0] : 4'h0);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) info_q <= sig;
	end

	// coefficient j is preloaded with one step so the first cycle already tests alpha^1
	for (genvar j = 1; j <= corr_t; j++) begin : g_coef
		gf_t coef_q;

		always_ff @(posedge clk) begin
			if (accept) coef_q <= gf_mul(sig_coef[j], gf_alpha_pow(j));
			else if (state == ch_search) coef_q <= gf_mul(coef_q, gf_alpha_pow(j));
		end

		assign term[j] = coef_q;
	end

	always_comb begin
		eval = gf_one;
		for (int j = 1; j <= corr_t; j++)
			eval ^= term[j];
	end

	assign root_valid = (state == ch_search);
	assign root_first = root_valid && (step_cnt == gf_alpha);
	assign root_last = root_valid && (step_cnt == gf_one);
	assign root_hit = root_valid && (eval == '0);
	assign root_info = info_q;

	// a burst is exactly fifteen flags, first and last at its two ends
	burst_a: assert property (@(posedge clk) disable iff (!rst_n)
		root_first |-> root_valid && !root_last
		##1 (root_valid && !root_first && !root_last) [*(code_n - 2)]
		##1 (root_valid && root_last));

endmodule

//--- logic/bch_correct.sv
`timescale 1ns/1ns

module bch_correct
	import bch_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     root_valid,
	input  logic     root_first,
	input  logic     root_last,
	input  logic     root_hit,
	input  sigma_t   root_info,
	output logic     free,
	output logic     out_valid,
	input  logic     out_ready,
	output result_t  out_result
);

	code_t      mask_q;     // first flag belongs to bit 14 and ends up at the top
	code_t      mask_next;
	logic [3:0] cnt_q;
	logic [3:0] cnt_next;
	logic       miss;

	assign free = !out_valid;

	always_comb begin
		mask_next = {mask_q[code_n-2:0], root_hit};
		cnt_next = cnt_q + {3'b000, root_hit};
		if (root_first) begin
			mask_next = {{(code_n - 1){1'b0}}, root_hit};
			cnt_next = {3'b000, root_hit};
		end
		// root count must agree with the locator degree, otherwise leave the word alone
		miss = (root_info.deg > corr_t) || (cnt_next != {2'b00, root_info.deg});
	end

	always_ff @(posedge clk) begin
		if (root_valid) begin
			mask_q <= mask_next;
			cnt_q <= cnt_next;
		end
		if (root_valid && root_last) begin
			out_result.word <= miss ? root_info.word : root_info.word ^ mask_next;
			out_result.err_count <= miss ? 2'd0 : root_info.deg;
			out_result.fail <= miss;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			if (root_valid && root_last) out_valid <= 1'b1;
			else if (out_ready) out_valid <= 1'b0;
		end
	end

	// the Chien stage must not start a burst into an occupied result register
	no_overrun_a: assert property (@(posedge clk) disable iff (!rst_n)
		root_valid |-> !out_valid);

endmodule

//--- logic/bch_decoder.sv
`timescale 1ns/1ns

module bch_decoder
	import bch_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  code_t    in_word,
	output logic     out_valid,
	input  logic     out_ready,
	output result_t  out_result
);

	logic   syn_valid;
	logic   syn_ready;
	syn_t   syn;
	logic   sig_valid;
	logic   sig_ready;
	sigma_t sig;
	logic   root_valid;
	logic   root_first;
	logic   root_last;
	logic   root_hit;
	sigma_t root_info;
	logic   free;       // result register empty, so a Chien burst may start

	bch_syndrome u_syndrome (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_ready(in_ready), .in_word(in_word),
		.syn_valid(syn_valid), .syn_ready(syn_ready), .syn(syn)
	);

	bch_sigma u_sigma (
		.clk(clk), .rst_n(rst_n),
		.syn_valid(syn_valid), .syn_ready(syn_ready), .syn(syn),
		.sig_valid(sig_valid), .sig_ready(sig_ready), .sig(sig)
	);

	bch_chien u_chien (
		.clk(clk), .rst_n(rst_n),
		.sig_valid(sig_valid), .sig_ready(sig_ready), .sig(sig),
		.root_valid(root_valid), .root_first(root_first), .root_last(root_last),
		.root_hit(root_hit), .root_info(root_info), .sink_free(free)
	);

	bch_correct u_correct (
		.clk(clk), .rst_n(rst_n),
		.root_valid(root_valid), .root_first(root_first), .root_last(root_last),
		.root_hit(root_hit), .root_info(root_info), .free(free),
		.out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
	);

endmodule

//--- logic/bch_pkg.sv
package bch_pkg;

	localparam int gf_m = 4;            // bits per field element
	localparam int code_n = 15;         // codeword length
	localparam int data_k = 7;          // message bits per codeword
	localparam int corr_t = 2;          // correctable errors
	localparam logic [4:0] field_poly = 5'h13;  // x^4 + x + 1
	localparam logic [8:0] gen_poly = 9'h1D1;   // lcm of the minimal polynomials of alpha and alpha^3

	typedef logic [gf_m-1:0] gf_t;
	typedef logic [code_n-1:0] code_t;

	// alog_table[i] is alpha^i, log_table[a] is the exponent of a (entry 0 is unused)
	localparam gf_t alog_table [0:code_n-1] = '{
		4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hC, 4'hB,
		4'h5, 4'hA, 4'h7, 4'hE, 4'hF, 4'hD, 4'h9
	};
	localparam gf_t log_table [0:15] = '{
		4'h0, 4'h0, 4'h1, 4'h4, 4'h2, 4'h8, 4'h5, 4'hA,
		4'h3, 4'hE, 4'h9, 4'h7, 4'h6, 4'hD, 4'hB, 4'hC
	};

	localparam gf_t gf_one = 4'h1;
	localparam gf_t gf_alpha = alog_table[1];
	localparam gf_t gf_alpha3 = alog_table[3];

	typedef struct packed {
		code_t word;
		gf_t   s1;
		gf_t   s3;
	} syn_t;

	typedef struct packed {
		code_t      word;
		gf_t        sig1;
		gf_t        sig2;
		logic [1:0] deg;    // 3 means no locator of degree two or less fits
	} sigma_t;

	typedef struct packed {
		code_t      word;
		logic [1:0] err_count;
		logic       fail;
	} result_t;

	typedef enum logic [1:0] {syn_idle, syn_shift, syn_full} syn_state_t;
	typedef enum logic [1:0] {ch_idle, ch_search, ch_hold} chien_state_t;

	function automatic gf_t gf_mul(input gf_t a, input gf_t b);
		logic [2*gf_m-2:0] prod;
		prod = '0;
		for (int i = 0; i < gf_m; i++)
			if (b[i]) prod ^= ({3'b000, a} << i);    // carry-less product
		for (int i = 2*gf_m-2; i >= gf_m; i--)
			if (prod[i]) prod ^= ({2'b00, field_poly} << (i - gf_m));  // reduce from the top
		return prod[gf_m-1:0];
	endfunction

	function automatic gf_t gf_inv(input gf_t a);
		if (a == '0) return '0;   // zero has no inverse
		return alog_table[(code_n - int'(log_table[a])) % code_n];
	endfunction

	function automatic gf_t gf_alpha_pow(input int e);
		return alog_table[e % code_n];
	endfunction

endpackage

//--- logic/bch_sigma.sv
`timescale 1ns/1ns

module bch_sigma
	import bch_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    syn_valid,
	output logic    syn_ready,
	input  syn_t    syn,
	output logic    sig_valid,
	input  logic    sig_ready,
	output sigma_t  sig
);

	gf_t    s1_cube;
	gf_t    s3_diff;
	sigma_t sig_next;
	sigma_t sig_q;

	assign s1_cube = gf_mul(gf_mul(syn.s1, syn.s1), syn.s1);
	assign s3_diff = syn.s3 ^ s1_cube;    // zero for a single error

	// Peterson solution for two errors in a binary code
	always_comb begin
		sig_next.word = syn.word;
		sig_next.sig1 = '0;
		sig_next.sig2 = '0;
		sig_next.deg = 2'd0;
		if (syn.s1 == '0) begin
			// no error, or a pattern beyond the code's reach
			if (syn.s3 != '0) sig_next.deg = 2'd3;
		end else if (s3_diff == '0) begin
			sig_next.sig1 = syn.s1;
			sig_next.deg = 2'd1;
		end else begin
			sig_next.sig1 = syn.s1;
			sig_next.sig2 = gf_mul(s3_diff, gf_inv(syn.s1));
			sig_next.deg = 2'd2;
		end
	end

	// one-entry output register, refilled in the cycle it empties
	assign syn_ready = !sig_valid || sig_ready;
	assign sig = sig_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sig_valid <= 1'b0;
		end else begin
			if (syn_valid && syn_ready) sig_valid <= 1'b1;
			else if (sig_ready) sig_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (syn_valid && syn_ready) sig_q <= sig_next;
	end

endmodule

//--- logic/bch_syndrome.sv
`timescale 1ns/1ns

module bch_syndrome
	import bch_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   in_valid,
	output logic   in_ready,
	input  code_t  in_word,
	output logic   syn_valid,
	input  logic   syn_ready,
	output syn_t   syn
);

	syn_state_t state;
	logic [3:0] bit_cnt;    // number of bits already folded in
	code_t      shift_q;    // next bit to fold sits at the top
	syn_t       syn_q;
	logic       accept;
	logic       cur_bit;

	// a finished syndrome can be handed on and a new word taken in the same cycle
	assign in_ready = (state == syn_idle) || (state == syn_full && syn_ready);
	assign accept = in_valid && in_ready;
	assign syn_valid = (state == syn_full);
	assign syn = syn_q;
	assign cur_bit = shift_q[code_n-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= syn_idle;
			bit_cnt <= '0;
		end else begin
			case (state)
				syn_idle: begin
					if (accept) state <= syn_shift;
				end
				syn_shift: begin
					if (bit_cnt == 4'(code_n - 1)) state <= syn_full;
				end
				syn_full: begin
					if (accept) state <= syn_shift;
					else if (syn_ready) state <= syn_idle;
				end
				default: state <= syn_idle;
			endcase
			if (accept) bit_cnt <= '0;
			else if (state == syn_shift) bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// Horner's rule at alpha and alpha^3, highest bit first
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_q <= in_word;
			syn_q.word <= in_word;
			syn_q.s1 <= '0;
			syn_q.s3 <= '0;
		end else if (state == syn_shift) begin
			shift_q <= {shift_q[code_n-2:0], 1'b0};
			syn_q.s1 <= gf_mul(syn_q.s1, gf_alpha) ^ {3'b000, cur_bit};
			syn_q.s3 <= gf_mul(syn_q.s3, gf_alpha3) ^ {3'b000, cur_bit};
		end
	end

	// the sigma stage may sample the payload any cycle it is offered
	syn_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		syn_valid && !syn_ready |=> syn_valid && $stable(syn));

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the BCH(15,7) decoder testbench with Verilator, runs it into sim.log and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module bch_decoder_tb \
	-f files.f -o bch_decoder_sim || { echo "build failed"; exit 1; }
./obj_dir/bch_decoder_sim > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "RESULT: PASS" sim.log && ! grep -q "RESULT: FAIL" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- verif/bch_decoder_tb.sv
`timescale 1ns/1ns

module bch_decoder_tb
	import bch_pkg::*;
();

	localparam int num_rows = 16;
	localparam int row_latency = 32;                // accept to out_valid with out_ready high
	localparam int timeout_cycles = num_rows * row_latency * 4 + 200;
	localparam int stall_start = 150;               // out_ready held low in this window
	localparam int stall_end = 270;

	typedef struct packed {
		logic [data_k-1:0] msg;
		code_t             mask;    // bits flipped on the way into the decoder
		logic [1:0]        n_err;   // expected err_count
	} row_t;

	// clean words, single errors at both ends and inside, then double errors
	localparam row_t stim_tab [0:num_rows-1] = '{
		'{7'h00, 15'h0000, 2'd0},
		'{7'h5A, 15'h0000, 2'd0},
		'{7'h7F, 15'h0000, 2'd0},
		'{7'h01, 15'h0001, 2'd1},
		'{7'h23, 15'h4000, 2'd1},
		'{7'h44, 15'h0080, 2'd1},
		'{7'h3C, 15'h0100, 2'd1},
		'{7'h12, 15'h0008, 2'd1},
		'{7'h6B, 15'h4001, 2'd2},
		'{7'h55, 15'h0060, 2'd2},
		'{7'h2A, 15'h6000, 2'd2},
		'{7'h71, 15'h0003, 2'd2},
		'{7'h0F, 15'h0804, 2'd2},
		'{7'h66, 15'h0210, 2'd2},
		'{7'h19, 15'h0400, 2'd1},
		'{7'h40, 15'h0000, 2'd0}
	};

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	logic    in_ready;
	code_t   in_word;
	logic    out_valid;
	logic    out_ready;
	result_t out_result;
	integer  seed = 35519;
	int      tx_count;
	int      rx_count;
	int      cyc;
	logic    saw_full;      // an input waited longer than one syndrome pass

	bch_decoder u_bch_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_word(in_word),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result)
	);

	// systematic encoding, message in bits 14..8 and the remainder mod gen_poly below it
	function automatic code_t encode(input logic [data_k-1:0] msg);
		code_t rem;
		rem = {msg, 8'h00};
		for (int i = code_n - 1; i >= code_n - data_k; i--)
			if (rem[i]) rem ^= (code_t'(gen_poly) << (i - (code_n - data_k)));
		return {msg, rem[code_n-data_k-1:0]};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input code_t got, input code_t exp, input int row);
		if (got !== exp) begin
			$display("error at %0t ns: row %0d word %h, expected %h", $time, row, got, exp);
			abort_run("the decoder returned a wrong codeword");
		end
	endtask

	task automatic check_count(input logic [1:0] got, input logic [1:0] exp, input int row);
		if (got !== exp) begin
			$display("error at %0t ns: row %0d err_count %0d, expected %0d", $time, row, got, exp);
			abort_run("the decoder returned a wrong error count");
		end
	endtask

	task automatic check_fail(input logic got, input logic exp, input int row);
		if (got !== exp) begin
			$display("error at %0t ns: row %0d fail %b, expected %b", $time, row, got, exp);
			abort_run("the decoder flagged a wrong failure state");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (!in_ready || out_valid) abort_run("in_ready low or out_valid high right after reset");
		wait (rx_count == num_rows);
		repeat (40) begin
			@(negedge clk);
			if (out_valid) abort_run("out_valid rose again after the last row came out");
		end
		if (saw_full) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			abort_run("in_ready never stayed low long enough to show a full pipeline");
		end
	end

	// rows go in back to back, holding in_valid until each one is taken
	initial begin
		int wait_cnt;
		tx_count = 0;
		wait_cnt = 0;
		saw_full = 1'b0;
		wait (rst_n === 1'b1);
		@(posedge clk);
		in_valid <= 1'b1;
		in_word <= encode(stim_tab[0].msg) ^ stim_tab[0].mask;
		while (tx_count < num_rows) begin
			@(negedge clk);
			if (in_ready) begin
				wait_cnt = 0;
				@(posedge clk);
				tx_count++;
				if (tx_count < num_rows)
					in_word <= encode(stim_tab[tx_count].msg) ^ stim_tab[tx_count].mask;
				else
					in_valid <= 1'b0;
			end else begin
				wait_cnt++;
				if (wait_cnt > code_n) saw_full = 1'b1;   // 15 busy cycles are one normal pass
			end
		end
	end

	// results are compared in order in the cycle before they are taken
	initial begin
		rx_count = 0;
		wait (rst_n === 1'b1);
		while (rx_count < num_rows) begin
			@(negedge clk);
			if (out_valid && tx_count == 0) abort_run("out_valid rose before any input was taken");
			if (out_valid && out_ready) begin
				check_word(out_result.word, encode(stim_tab[rx_count].msg), rx_count);
				check_count(out_result.err_count, stim_tab[rx_count].n_err, rx_count);
				check_fail(out_result.fail, 1'b0, rx_count);
				rx_count++;
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		cyc = 0;
		wait (rst_n === 1'b1);
		forever begin
			@(posedge clk);
			cyc++;
			rnd = $random(seed);
			if (cyc >= stall_start && cyc < stall_end) out_ready <= 1'b0;  // long stall fills the pipe
			else out_ready <= rnd[0];
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk);
		abort_run($sformatf("timeout after %0d cycles with %0d of %0d results received",
			timeout_cycles, rx_count, num_rows));
	end

endmodule
